/* bench/clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk  = 1'b0;
    rstn = 1'b0;
    repeat (4) @(posedge clk);
    #1 rstn = 1'b1;  // released clear of the edge
  end

  always #20 clk = ~clk;  // 40 ns period

endmodule

`default_nettype wire

/* bench/tb_kernel.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_kernel;

  import kernel_pkg::*;

  logic                   clk;
  logic                   rstn;
  logic                   host_en;
  logic [3:0]             host_we;
  logic [HOST_ADDR_W-1:0] host_addr;
  logic [HOST_DATA_W-1:0] host_din;
  logic [HOST_DATA_W-1:0] host_dout;
  logic                   ocu_rstn;
  axi_ax_t                aw;
  logic                   awvalid;
  logic                   awready;
  axi_w_t                 w;
  logic                   wvalid;
  logic                   wready;
  axi_ax_t                ar;
  logic                   arvalid;
  logic                   arready;
  axi_b_t                 b;
  logic                   bvalid;
  logic                   bready;
  axi_r_t                 r;
  logic                   rvalid;
  logic                   rready;

  logic [31:0] stage_m [8];  // what the staging buffer should hold
  axi_ax_t     aw_exp_q [$];
  axi_w_t      w_exp_q [$];
  axi_ax_t     ar_exp_q [$];
  axi_b_t      b_exp_q [$];
  axi_r_t      r_exp_q [$];
  axi_ax_t     aw_exp;
  axi_w_t      w_exp;
  axi_ax_t     ar_exp;
  logic        aw_ok;
  logic        w_ok;
  logic        ar_ok;
  logic        aw_hs;
  logic        w_hs;
  logic        ar_hs;
  logic [31:0] exp_dout;
  logic        dout_chk;
  logic        exp_ocu;
  logic        fresh;
  logic        hold_ready;
  int          errors = 0;
  int          n_aw = 0;
  int          n_w = 0;
  int          n_ar = 0;

  clk_gen i_clk_gen (.clk(clk), .rstn(rstn));

  kernel i_dut (.*);

  // all checks sit at the falling edge where every signal is settled
  aw_beat: assert property (@(negedge clk) disable iff (!rstn)
    (awvalid && awready) |-> (aw_ok && aw == aw_exp))
  else begin
    errors++;
    $display("ERR %0t aw exp %h got %h", $time, aw_exp, aw);
  end

  w_beat: assert property (@(negedge clk) disable iff (!rstn)
    (wvalid && wready) |-> (w_ok && w == w_exp))
  else begin
    errors++;
    $display("ERR %0t w exp %h got %h", $time, w_exp, w);
  end

  ar_beat: assert property (@(negedge clk) disable iff (!rstn)
    (arvalid && arready) |-> (ar_ok && ar == ar_exp))
  else begin
    errors++;
    $display("ERR %0t ar exp %h got %h", $time, ar_exp, ar);
  end

  dout_value: assert property (@(negedge clk) dout_chk |-> host_dout == exp_dout)
  else begin
    errors++;
    $display("ERR %0t host_dout exp %h got %h", $time, exp_dout, host_dout);
  end

  ocu_value: assert property (@(negedge clk) ocu_rstn == exp_ocu)
  else begin
    errors++;
    $display("ERR %0t ocu_rstn exp %b got %b", $time, exp_ocu, ocu_rstn);
  end

  idle_after_reset: assert property (@(negedge clk)
    fresh |-> (!awvalid && !wvalid && !arvalid && bready && rready))
  else begin
    errors++;
    $display("%0t: AXI valids or readies not in their reset state", $time);
  end

  always @(negedge clk) begin
    aw_hs <= awvalid && awready;  // beat moves at the coming edge
    w_hs  <= wvalid && wready;
    ar_hs <= arvalid && arready;
  end

  // retire accepted beats and expose the next expected head
  always @(posedge clk) begin
    #1;
    if (aw_hs && aw_exp_q.size() > 0) begin
      void'(aw_exp_q.pop_front());
      n_aw++;
    end
    if (w_hs && w_exp_q.size() > 0) begin
      void'(w_exp_q.pop_front());
      n_w++;
    end
    if (ar_hs && ar_exp_q.size() > 0) begin
      void'(ar_exp_q.pop_front());
      n_ar++;
    end
    aw_ok = aw_exp_q.size() > 0;
    w_ok  = w_exp_q.size() > 0;
    ar_ok = ar_exp_q.size() > 0;
    aw_exp = aw_ok ? aw_exp_q[0] : '0;
    w_exp  = w_ok ? w_exp_q[0] : '0;
    ar_exp = ar_ok ? ar_exp_q[0] : '0;
  end

  always @(posedge clk) begin : ready_gen
    logic pause;
    pause = hold_ready;
    #2;
    {awready, wready, arready} = pause ? 3'b000 : 3'($urandom);  // random back-pressure
  end

  function automatic axi_ax_t ax_expect(logic [63:0] addr, logic [2:0] size, logic [3:0] id);
    axi_ax_t ax;
    ax       = '0;
    ax.addr  = addr;
    ax.size  = size;
    ax.burst = 2'd1;  // INCR
    ax.len   = 8'd0;
    ax.id    = id;
    return ax;
  endfunction

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic host_write(input logic [14:0] addr, input logic [31:0] data);
    host_en   = 1'b1;
    host_we   = 4'hf;
    host_addr = addr;
    host_din  = data;
    @(posedge clk);
    #2;
    host_en = 1'b0;
    host_we = 4'h0;
  endtask

  task automatic host_read_check(input logic [14:0] addr, input logic [31:0] exp);
    host_en   = 1'b1;
    host_we   = 4'h0;
    host_addr = addr;
    @(posedge clk);
    #2;
    host_en  = 1'b0;
    exp_dout = exp;
    dout_chk = 1'b1;
    @(posedge clk);
    #2;
    dout_chk = 1'b0;
  endtask

  task automatic fill_stage();
    int i;
    logic [31:0] v;
    for (i = 0; i < 8; i++) begin
      v = $urandom;
      host_write(15'(4 * i), v);
      stage_m[i] = v;
    end
  endtask

  task automatic check_stage();
    int i;
    for (i = 0; i < 8; i++) begin
      host_read_check(15'(4 * i), stage_m[i]);
    end
  endtask

  task automatic push_requests();
    axi_w_t wb;
    wb.data = {stage_m[3], stage_m[2], stage_m[1], stage_m[0]};
    wb.strb = stage_m[4][15:0];
    wb.last = 1'b1;
    aw_exp_q.push_back(ax_expect({stage_m[1], stage_m[0]}, stage_m[2][2:0], 4'd1));
    w_exp_q.push_back(wb);
    host_write(REG_AW_PUSH, 32'd0);
    host_write(REG_W_PUSH, 32'd0);
    fill_stage();  // read request gets its own address
    ar_exp_q.push_back(ax_expect({stage_m[1], stage_m[0]}, stage_m[2][2:0], 4'd2));
    host_write(REG_AR_PUSH, 32'd0);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (aw_exp_q.size() + w_exp_q.size() + ar_exp_q.size() != 0) begin
      if (n == 500) abort_run("request queues never drained on the AXI side");
      @(posedge clk);
      #2;
      n++;
    end
  endtask

  task automatic send_resp(input bit to_r);
    axi_b_t nb;
    axi_r_t nr;
    int n;
    nb.id   = 4'($urandom);
    nb.resp = 2'($urandom);
    nr.id   = 4'($urandom);
    nr.resp = 2'($urandom);
    nr.data = {$urandom, $urandom, $urandom, $urandom};
    nr.last = 1'b1;
    n = 0;
    while (!(to_r ? rready : bready)) begin
      if (n == 50) abort_run("response ready stayed low");
      @(posedge clk);
      #2;
      n++;
    end
    if (to_r) begin
      r      = nr;
      rvalid = 1'b1;
      r_exp_q.push_back(nr);
    end else begin
      b      = nb;
      bvalid = 1'b1;
      b_exp_q.push_back(nb);
    end
    @(posedge clk);
    #2;
    bvalid = 1'b0;
    rvalid = 1'b0;
  endtask

  task automatic pop_resp(input bit from_r);
    axi_b_t hb;
    axi_r_t hr;
    int i;
    for (i = 0; i < 8; i++) begin
      stage_m[i] = '0;
    end
    if (from_r) begin
      hr = r_exp_q.pop_front();
      for (i = 0; i < 4; i++) begin
        stage_m[i] = hr.data[32*i +: 32];
      end
      stage_m[4] = {26'd0, hr.id, hr.resp};
      host_write(REG_R_POP, 32'd0);
    end else begin
      hb = b_exp_q.pop_front();
      stage_m[0] = {26'd0, hb.id, hb.resp};
      host_write(REG_B_POP, 32'd0);
    end
    @(posedge clk);  // staging loads one edge after the pop
    #2;
  endtask

  initial begin
    int n;
    int i;
    void'($urandom(32'hc0885b64));
    host_en    = 1'b0;
    host_we    = 4'h0;
    host_addr  = '0;
    host_din   = '0;
    awready    = 1'b0;
    wready     = 1'b0;
    arready    = 1'b0;
    b          = '0;
    bvalid     = 1'b0;
    r          = '0;
    rvalid     = 1'b0;
    dout_chk   = 1'b0;
    exp_ocu    = 1'b0;
    fresh      = 1'b0;
    hold_ready = 1'b0;
    n = 0;
    while (!rstn) begin
      if (n == 20) abort_run("reset was never released");
      @(posedge clk);
      #2;
      n++;
    end
    fresh = 1'b1;
    @(posedge clk);
    #2;
    exp_ocu = 1'b1;  // one cycle after release

    fill_stage();
    check_stage();
    fresh = 1'b0;

    hold_ready = 1'b1;  // let the request queues fill up
    for (i = 0; i < 6; i++) begin
      fill_stage();
      push_requests();
    end
    hold_ready = 1'b0;
    wait_drained();

    send_resp(1'b0);
    send_resp(1'b0);
    send_resp(1'b1);
    send_resp(1'b1);
    host_read_check(REG_B_STAT, 32'd1);
    host_read_check(REG_R_STAT, 32'd1);
    for (i = 0; i < 2; i++) begin
      pop_resp(1'b0);
      check_stage();
      pop_resp(1'b1);
      check_stage();
    end
    host_read_check(REG_B_STAT, 32'd0);
    host_read_check(REG_R_STAT, 32'd0);

    host_write(REG_OCU_ASSERT, 32'd1);
    @(posedge clk);
    #2;
    exp_ocu = 1'b0;
    host_write(REG_OCU_RELEASE, 32'd1);
    @(posedge clk);
    #2;
    exp_ocu = 1'b1;
    @(posedge clk);
    #2;

    $display("errors %0d, beats aw %0d w %0d ar %0d", errors, n_aw, n_w, n_ar);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/axi_master_port.sv */
`timescale 1ns/1ns
`default_nettype none

module axi_master_port (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  aw_push,
  input  kernel_pkg::addr_req_t aw_req,
  input  logic                  w_push,
  input  kernel_pkg::w_beat_t   w_beat,
  input  logic                  ar_push,
  input  kernel_pkg::addr_req_t ar_req,
  input  logic                  b_pop,
  output kernel_pkg::b_resp_t   b_head,
  output logic                  b_avail,
  input  logic                  r_pop,
  output kernel_pkg::r_beat_t   r_head,
  output logic                  r_avail,
  output kernel_pkg::axi_ax_t   aw,
  output logic                  awvalid,
  input  logic                  awready,
  output kernel_pkg::axi_w_t    w,
  output logic                  wvalid,
  input  logic                  wready,
  output kernel_pkg::axi_ax_t   ar,
  output logic                  arvalid,
  input  logic                  arready,
  input  kernel_pkg::axi_b_t    b,
  input  logic                  bvalid,
  output logic                  bready,
  input  kernel_pkg::axi_r_t    r,
  input  logic                  rvalid,
  output logic                  rready
);

  import kernel_pkg::*;

  addr_req_t aw_head;
  addr_req_t ar_head;
  w_beat_t   w_head;
  b_resp_t   b_in;
  r_beat_t   r_in;

  // request side, a push into a full queue is dropped
  bp_fifo #(.DATA_W($bits(addr_req_t)), .LOG2_DEPTH(FIFO_LOG2_DEPTH)) aw_q (
    .clk(clk), .rstn(rstn), .wvalid(aw_push), .wdata(aw_req), .wready(),
    .rvalid(awvalid), .rdata(aw_head), .rready(awready));

  bp_fifo #(.DATA_W($bits(w_beat_t)), .LOG2_DEPTH(FIFO_LOG2_DEPTH)) w_q (
    .clk(clk), .rstn(rstn), .wvalid(w_push), .wdata(w_beat), .wready(),
    .rvalid(wvalid), .rdata(w_head), .rready(wready));

  bp_fifo #(.DATA_W($bits(addr_req_t)), .LOG2_DEPTH(FIFO_LOG2_DEPTH)) ar_q (
    .clk(clk), .rstn(rstn), .wvalid(ar_push), .wdata(ar_req), .wready(),
    .rvalid(arvalid), .rdata(ar_head), .rready(arready));

  assign aw = ax_from_req(aw_head, AWID_FIXED);
  assign ar = ax_from_req(ar_head, ARID_FIXED);

  always_comb begin
    w.data = w_head.data;
    w.strb = w_head.strb;
    w.last = 1'b1;  // single beat bursts
  end

  // response side, rlast dropped
  assign b_in = '{id: b.id, resp: b.resp};
  assign r_in = '{id: r.id, resp: r.resp, data: r.data};

  bp_fifo #(.DATA_W($bits(b_resp_t)), .LOG2_DEPTH(FIFO_LOG2_DEPTH)) b_q (
    .clk(clk), .rstn(rstn), .wvalid(bvalid), .wdata(b_in), .wready(bready),
    .rvalid(b_avail), .rdata(b_head), .rready(b_pop));

  bp_fifo #(.DATA_W($bits(r_beat_t)), .LOG2_DEPTH(FIFO_LOG2_DEPTH)) r_q (
    .clk(clk), .rstn(rstn), .wvalid(rvalid), .wdata(r_in), .wready(rready),
    .rvalid(r_avail), .rdata(r_head), .rready(r_pop));

endmodule

`default_nettype wire

/* hdl/bp_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module bp_fifo #(
  parameter int DATA_W     = 8,
  parameter int LOG2_DEPTH = 4
) (
  input  logic              clk,
  input  logic              rstn,
  input  logic              wvalid,
  input  logic [DATA_W-1:0] wdata,
  output logic              wready,
  output logic              rvalid,
  output logic [DATA_W-1:0] rdata,
  input  logic              rready
);

  logic [DATA_W-1:0]   mem [2**LOG2_DEPTH];
  logic [LOG2_DEPTH:0] wr_ptr;  // extra msb tells full from empty
  logic [LOG2_DEPTH:0] rd_ptr;
  logic                full;
  logic                do_wr;
  logic                do_rd;

  assign full   = (wr_ptr[LOG2_DEPTH] != rd_ptr[LOG2_DEPTH]) &&
                  (wr_ptr[LOG2_DEPTH-1:0] == rd_ptr[LOG2_DEPTH-1:0]);
  assign wready = !full;
  assign rvalid = (wr_ptr != rd_ptr);
  assign rdata  = mem[rd_ptr[LOG2_DEPTH-1:0]];  // head
  assign do_wr  = wvalid && wready;
  assign do_rd  = rvalid && rready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[LOG2_DEPTH-1:0]] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* hdl/host_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module host_regs (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               host_en,
  input  logic [3:0]                         host_we,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0] host_addr,
  input  logic [kernel_pkg::HOST_DATA_W-1:0] host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0] host_dout,
  output logic                               ocu_rstn,
  output logic                               aw_push,
  output kernel_pkg::addr_req_t              aw_req,
  output logic                               w_push,
  output kernel_pkg::w_beat_t                w_beat,
  output logic                               ar_push,
  output kernel_pkg::addr_req_t              ar_req,
  output logic                               b_pop,
  input  kernel_pkg::b_resp_t                b_head,
  input  logic                               b_avail,
  output logic                               r_pop,
  input  kernel_pkg::r_beat_t                r_head,
  input  logic                               r_avail
);

  import kernel_pkg::*;

  stage_t stage;
  logic   host_wr;
  logic   host_rd;
  logic   ocu_sw;  // software reset bit, 0 holds the remote side in reset

  assign host_wr = host_en && (host_we != 4'd0);
  assign host_rd = host_en && (host_we == 4'd0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_push  <= 1'b0;
      w_push   <= 1'b0;
      ar_push  <= 1'b0;
      b_pop    <= 1'b0;
      r_pop    <= 1'b0;
      ocu_sw   <= 1'b1;
      ocu_rstn <= 1'b0;
    end else begin
      aw_push  <= host_wr && (host_addr == REG_AW_PUSH);
      w_push   <= host_wr && (host_addr == REG_W_PUSH);
      ar_push  <= host_wr && (host_addr == REG_AR_PUSH);
      b_pop    <= host_wr && (host_addr == REG_B_POP);
      r_pop    <= host_wr && (host_addr == REG_R_POP);
      ocu_rstn <= ocu_sw;  // one cycle behind the bit
      if (host_wr && (host_addr == REG_OCU_ASSERT)) begin
        ocu_sw <= 1'b0;
      end else if (host_wr && (host_addr == REG_OCU_RELEASE)) begin
        ocu_sw <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (host_wr) begin
      case (host_addr)
        REG_STAGE0, REG_STAGE1, REG_STAGE2, REG_STAGE3,
        REG_STAGE4, REG_STAGE5, REG_STAGE6, REG_STAGE7: begin
          stage[host_addr[4:2]] <= host_din;
        end
        REG_AW_PUSH: begin
          aw_req.addr <= {stage[1], stage[0]};
          aw_req.size <= stage[2][2:0];
        end
        REG_W_PUSH: begin
          w_beat.data <= {stage[3], stage[2], stage[1], stage[0]};
          w_beat.strb <= stage[4][AXI_STRB_W-1:0];
        end
        REG_AR_PUSH: begin
          ar_req.addr <= {stage[1], stage[0]};
          ar_req.size <= stage[2][2:0];
        end
        default: ;
      endcase
    end

    // head lands in the low bits, the rest cleared
    if (b_pop) begin
      stage <= stage_t'(b_head);
    end else if (r_pop) begin
      stage <= stage_t'(r_head);
    end

    if (host_rd) begin
      case (host_addr)
        REG_STAGE0, REG_STAGE1, REG_STAGE2, REG_STAGE3,
        REG_STAGE4, REG_STAGE5, REG_STAGE6, REG_STAGE7: begin
          host_dout <= stage[host_addr[4:2]];
        end
        REG_B_STAT: host_dout <= HOST_DATA_W'(b_avail);
        REG_R_STAT: host_dout <= HOST_DATA_W'(r_avail);
        default: ;  // unmapped, keep last value
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/kernel.sv */
`timescale 1ns/1ns
`default_nettype none

module kernel (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               host_en,
  input  logic [3:0]                         host_we,
  input  logic [kernel_pkg::HOST_ADDR_W-1:0] host_addr,
  input  logic [kernel_pkg::HOST_DATA_W-1:0] host_din,
  output logic [kernel_pkg::HOST_DATA_W-1:0] host_dout,
  output logic                               ocu_rstn,
  output kernel_pkg::axi_ax_t                aw,
  output logic                               awvalid,
  input  logic                               awready,
  output kernel_pkg::axi_w_t                 w,
  output logic                               wvalid,
  input  logic                               wready,
  output kernel_pkg::axi_ax_t                ar,
  output logic                               arvalid,
  input  logic                               arready,
  input  kernel_pkg::axi_b_t                 b,
  input  logic                               bvalid,
  output logic                               bready,
  input  kernel_pkg::axi_r_t                 r,
  input  logic                               rvalid,
  output logic                               rready
);

  import kernel_pkg::*;

  logic      aw_push;
  addr_req_t aw_req;
  logic      w_push;
  w_beat_t   w_beat;
  logic      ar_push;
  addr_req_t ar_req;
  logic      b_pop;
  b_resp_t   b_head;
  logic      b_avail;
  logic      r_pop;
  r_beat_t   r_head;
  logic      r_avail;

  host_regs i_host_regs (.*);  // host window and staging

  axi_master_port i_axi_master_port (.*);  // k2o queues

endmodule

`default_nettype wire

/* hdl/kernel_pkg.sv */
`default_nettype none

package kernel_pkg;

  localparam int AXI_ADDR_W      = 64;
  localparam int AXI_DATA_W      = 128;
  localparam int AXI_STRB_W      = 16;
  localparam int AXI_ID_W        = 4;
  localparam int HOST_ADDR_W     = 15;
  localparam int HOST_DATA_W     = 32;
  localparam int STAGE_WORDS     = 8;
  localparam int FIFO_LOG2_DEPTH = 4;  // 16 entries

  localparam logic [AXI_ID_W-1:0] AWID_FIXED = 4'd1;
  localparam logic [AXI_ID_W-1:0] ARID_FIXED = 4'd2;
  localparam logic [1:0]          BURST_INCR = 2'd1;

  typedef enum logic [HOST_ADDR_W-1:0] {
    REG_STAGE0      = 15'h00,
    REG_STAGE1      = 15'h04,
    REG_STAGE2      = 15'h08,
    REG_STAGE3      = 15'h0c,
    REG_STAGE4      = 15'h10,
    REG_STAGE5      = 15'h14,
    REG_STAGE6      = 15'h18,
    REG_STAGE7      = 15'h1c,
    REG_AW_PUSH     = 15'h20,
    REG_W_PUSH      = 15'h30,
    REG_AR_PUSH     = 15'h40,
    REG_B_STAT      = 15'h50,
    REG_B_POP       = 15'h54,
    REG_R_STAT      = 15'h60,
    REG_R_POP       = 15'h64,
    REG_OCU_ASSERT  = 15'hc0,
    REG_OCU_RELEASE = 15'hc4
  } host_reg_e;

  // word 0 sits in the low bits
  typedef logic [STAGE_WORDS-1:0][HOST_DATA_W-1:0] stage_t;

  typedef struct packed {
    logic [2:0]            size;
    logic [AXI_ADDR_W-1:0] addr;
  } addr_req_t;

  typedef struct packed {
    logic [AXI_STRB_W-1:0] strb;
    logic [AXI_DATA_W-1:0] data;
  } w_beat_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } b_resp_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
    logic [AXI_DATA_W-1:0] data;
  } r_beat_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [1:0]            burst;
    logic [3:0]            cache;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic                  lock;
    logic [2:0]            prot;
    logic [3:0]            qos;
    logic [2:0]            size;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [1:0]            resp;
    logic [AXI_DATA_W-1:0] data;
    logic                  last;
  } axi_r_t;

  // single beat INCR request, remaining fields zero
  function automatic axi_ax_t ax_from_req(addr_req_t req, logic [AXI_ID_W-1:0] id);
    axi_ax_t ax;
    ax       = '0;
    ax.addr  = req.addr;
    ax.size  = req.size;
    ax.burst = BURST_INCR;
    ax.id    = id;
    ax.len   = 8'd0;  // one beat
    return ax;
  endfunction

endpackage

`default_nettype wire

/* list.f */
hdl/kernel_pkg.sv
hdl/bp_fifo.sv
hdl/host_regs.sv
hdl/axi_master_port.sv
hdl/kernel.sv
bench/clk_gen.sv
bench/tb_kernel.sv

/* run.sh */
#!/bin/sh
# build and run the kernel testbench with Verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_kernel -f list.f &&
  ./obj_dir/Vtb_kernel 2>&1 | tee sim.log

grep -qx "Testbench passed" sim.log && echo "simulation ok" ||
  { echo "simulation failed, see sim.log"; exit 1; }
